// File: intomips_soc.f
rtl/intomips_soc_pkg.sv
rtl/bus_router.sv
rtl/sram_controller.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/intomips_soc_top.sv
dv/sram_model.sv
dv/tb_intomips_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_intomips_soc
RTL_TOP   ?= intomips_soc_top
FILELIST  ?= intomips_soc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_intomips_soc.sv
`timescale 1ns/1ns

module tb_intomips_soc import intomips_soc_pkg::*; ();

    localparam int MAX_REQ       = 80;
    localparam int WATCHDOG_CYCS = MAX_REQ * 8 + 12 * 10 * UART_CLKS_PER_BIT;

    logic      clk, rst_n, inst_re, stall, irq, txd;
    word_t     inst_addr, inst_rdata, data_rdata, base_ram_data, ext_ram_data;
    cpu_req_t  data_req;
    sram_out_t base_ram, ext_ram;

    integer seed = 8295;
    int     errors = 0;
    int     timeouts = 0;
    int     stall_total = 0;  // stalled cycles since reset
    int     stall_base, exp_stall, wait_cnt;
    logic   check_now = 0, chk_idle = 0, chk_inst = 0, chk_data = 0, chk_irq = 0;
    logic   exp_irq = 0;
    word_t  exp_inst, exp_data, a, wd;
    logic [7:0] tx_val;
    word_t  sb [word_t];      // scoreboard, keyed by word-aligned address
    word_t  addrs [$];

    intomips_soc_top u_dut (
        .clk_25m_i       (clk),
        .rst_n_i         (rst_n),
        .inst_re_i       (inst_re),
        .inst_addr_i     (inst_addr),
        .data_req_i      (data_req),
        .inst_rdata_o    (inst_rdata),
        .data_rdata_o    (data_rdata),
        .stall_o         (stall),
        .irq_o           (irq),
        .base_ram_o      (base_ram),
        .ext_ram_o       (ext_ram),
        .base_ram_data_i (base_ram_data),
        .ext_ram_data_i  (ext_ram_data),
        .txd_o           (txd),
        .rxd_i           (txd)    // serial loopback
    );

    sram_model u_base_ram (.clk_i(clk), .ram_i(base_ram), .data_o(base_ram_data));
    sram_model u_ext_ram  (.clk_i(clk), .ram_i(ext_ram),  .data_o(ext_ram_data));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (stall) stall_total <= stall_total + 1;
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n) chk_idle |->
        (!stall && !irq && txd && base_ram.ce_n && base_ram.oe_n && base_ram.we_n
         && ext_ram.ce_n && ext_ram.oe_n && ext_ram.we_n))
        else begin
            errors++;
            $display("FAIL idle stall_o=%h irq_o=%h txd_o=%h base_ram_o=%h ext_ram_o=%h",
                     $sampled(stall), $sampled(irq), $sampled(txd),
                     $sampled(base_ram), $sampled(ext_ram));
        end

    a_stall: assert property (@(posedge clk) check_now |-> stall_total - stall_base == exp_stall)
        else begin
            errors++;
            $display("FAIL stall_o cycles got %h exp %h",
                     $sampled(stall_total) - stall_base, exp_stall);
        end

    a_inst: assert property (@(posedge clk) (check_now && chk_inst) |-> inst_rdata == exp_inst)
        else begin
            errors++;
            $display("FAIL inst_rdata_o got %h exp %h", $sampled(inst_rdata), exp_inst);
        end

    a_data: assert property (@(posedge clk) (check_now && chk_data) |-> data_rdata == exp_data)
        else begin
            errors++;
            $display("FAIL data_rdata_o got %h exp %h", $sampled(data_rdata), exp_data);
        end

    a_irq: assert property (@(posedge clk) (check_now && chk_irq) |-> irq == exp_irq)
        else begin
            errors++;
            $display("FAIL irq_o got %h exp %h", $sampled(irq), exp_irq);
        end

    function automatic cpu_req_t make_req(logic re, logic we, word_t addr, word_t wdata,
                                          mask_t mask);
        cpu_req_t r;
        r.re    = re;
        r.we    = we;
        r.addr  = addr;
        r.wdata = wdata;
        r.mask  = mask;
        return r;
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t nw, mask_t mask);
        word_t m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) m[8*b +: 8] = nw[8*b +: 8];
        end
        return m;
    endfunction

    // drive on the falling edge, hold through the stall, check in the first free cycle
    task automatic access(input logic ire, input word_t iaddr, input cpu_req_t dreq,
                          input int st, input logic ci, input word_t ei,
                          input logic cd, input word_t ed);
        @(negedge clk);
        inst_re    = ire;
        inst_addr  = iaddr;
        data_req   = dreq;
        stall_base = stall_total;
        exp_stall  = st;
        chk_inst   = ci;
        exp_inst   = ei;
        chk_data   = cd;
        exp_data   = ed;
        do @(negedge clk); while (stall);
        check_now = 1'b1;
        @(negedge clk);
        check_now = 1'b0;
        inst_re   = 1'b0;
        data_req  = '0;
    endtask

    task automatic write_word(input word_t addr, input word_t data, input mask_t mask);
        sb[addr] = merge_bytes(sb.exists(addr) ? sb[addr] : 32'h0, data, mask);
        access(1'b0, '0, make_req(1'b0, 1'b1, addr, data, mask), 2, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic read_check(input word_t addr);
        access(1'b0, '0, make_req(1'b1, 1'b0, addr, '0, '0), 2, 1'b0, '0, 1'b1, sb[addr]);
    endtask

    initial begin
        repeat (WATCHDOG_CYCS) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        inst_re   = 1'b0;
        inst_addr = '0;
        data_req  = '0;
        repeat (4) @(negedge clk);
        rst_n    = 1'b1;
        chk_idle = 1'b1;                       // outputs quiet with no request
        repeat (3) @(negedge clk);
        chk_idle = 1'b0;

        for (int i = 0; i < 16; i++) begin     // masked writes then reads
            a = ((i % 2) ? EXT_LO : BASE_LO) | ($random(seed) & 32'h003F_FFFC);
            addrs.push_back(a);
            write_word(a, $random(seed), 4'hf);
            write_word(a, $random(seed), 4'($random(seed)));
            read_check(a);
        end

        // fetch and data on different srams, then on the same one
        access(1'b1, addrs[0], make_req(1'b1, 1'b0, addrs[1], '0, '0), 2,
               1'b1, sb[addrs[0]], 1'b1, sb[addrs[1]]);
        access(1'b1, addrs[0], make_req(1'b1, 1'b0, addrs[2], '0, '0), 4,
               1'b1, sb[addrs[0]], 1'b1, sb[addrs[2]]);
        access(1'b1, addrs[1], make_req(1'b1, 1'b0, addrs[3], '0, '0), 4,
               1'b1, sb[addrs[1]], 1'b1, sb[addrs[3]]);

        // unmapped reads return zero, unmapped writes land nowhere
        access(1'b0, '0, make_req(1'b1, 1'b0, 32'h0000_1000, '0, '0), 0, 1'b0, '0, 1'b1, '0);
        wd = $random(seed);
        access(1'b0, '0, make_req(1'b0, 1'b1, 32'h8080_0000 | (addrs[0] & 32'h003F_FFFC),
               wd, 4'hf), 0, 1'b0, '0, 1'b0, '0);
        read_check(addrs[0]);

        // uart loopback
        tx_val = 8'($random(seed));
        access(1'b0, '0, make_req(1'b0, 1'b1, UART_DATA_ADDR, {24'h0, tx_val}, 4'h1), 0,
               1'b0, '0, 1'b0, '0);
        access(1'b0, '0, make_req(1'b1, 1'b0, UART_STATUS_ADDR, '0, '0), 0,
               1'b0, '0, 1'b1, 32'h0);
        wait_cnt = 0;
        while (!irq && wait_cnt < 2 * 10 * UART_CLKS_PER_BIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!irq) begin
            timeouts++;
            $display("irq_o never rose after the loopback frame");
        end
        repeat (UART_CLKS_PER_BIT) @(negedge clk);  // let the stop bit finish
        chk_irq = 1'b1;
        exp_irq = 1'b1;
        access(1'b0, '0, make_req(1'b1, 1'b0, UART_STATUS_ADDR, '0, '0), 0,
               1'b0, '0, 1'b1, 32'h3);
        // fetches from uart registers read zero and leave the byte pending
        access(1'b1, UART_DATA_ADDR, '0, 0, 1'b1, '0, 1'b0, '0);
        access(1'b1, UART_STATUS_ADDR, '0, 0, 1'b1, '0, 1'b0, '0);
        exp_irq = 1'b0;                        // the data read clears it
        access(1'b0, '0, make_req(1'b1, 1'b0, UART_DATA_ADDR, '0, '0), 0,
               1'b0, '0, 1'b1, {24'h0, tx_val});
        chk_irq = 1'b0;

        repeat (2) @(negedge clk);
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dv/sram_model.sv
`timescale 1ns/1ns

module sram_model import intomips_soc_pkg::*; (
    input  logic      clk_i,   // only used to time the write mid-cycle
    input  sram_out_t ram_i,
    output word_t     data_o
);

    word_t mem [0:(1 << 20) - 1];

    // strobe inputs are stable at the falling edge of the strobe cycle
    always @(negedge clk_i) begin
        if (!ram_i.ce_n && !ram_i.we_n && ram_i.dout_en) begin
            for (int b = 0; b < 4; b++) begin
                if (!ram_i.be_n[b]) begin
                    mem[ram_i.addr][8*b +: 8] <= ram_i.dout[8*b +: 8];
                end
            end
        end
    end

    // reads are combinational while chip and output enables are low
    assign data_o = (!ram_i.ce_n && !ram_i.oe_n) ? mem[ram_i.addr] : 32'h0;

endmodule

// File: rtl/intomips_soc_top.sv
`timescale 1ns/1ns

module intomips_soc_top import intomips_soc_pkg::*; (
    input  logic      clk_25m_i,
    input  logic      rst_n_i,
    input  logic      inst_re_i,
    input  word_t     inst_addr_i,
    input  cpu_req_t  data_req_i,
    output word_t     inst_rdata_o,
    output word_t     data_rdata_o,
    output logic      stall_o,
    output logic      irq_o,
    output sram_out_t base_ram_o,
    output sram_out_t ext_ram_o,
    input  word_t     base_ram_data_i,
    input  word_t     ext_ram_data_i,
    output logic      txd_o,
    input  logic      rxd_i
);

    cpu_req_t   base_a, base_b, ext_a, ext_b;
    word_t      base_a_rdata, base_b_rdata, ext_a_rdata, ext_b_rdata;
    logic       base_stall, ext_stall;
    logic       tx_start, tx_busy;
    logic [7:0] tx_byte, rx_byte;
    logic       rx_valid, rx_clear;

    bus_router u_bus_router (
        .clk_25m_i      (clk_25m_i),
        .rst_n_i        (rst_n_i),
        .inst_re_i      (inst_re_i),
        .inst_addr_i    (inst_addr_i),
        .data_req_i     (data_req_i),
        .inst_rdata_o   (inst_rdata_o),
        .data_rdata_o   (data_rdata_o),
        .base_a_o       (base_a),
        .base_b_o       (base_b),
        .ext_a_o        (ext_a),
        .ext_b_o        (ext_b),
        .base_a_rdata_i (base_a_rdata),
        .base_b_rdata_i (base_b_rdata),
        .ext_a_rdata_i  (ext_a_rdata),
        .ext_b_rdata_i  (ext_b_rdata),
        .tx_start_o     (tx_start),
        .tx_byte_o      (tx_byte),
        .tx_busy_i      (tx_busy),
        .rx_byte_i      (rx_byte),
        .rx_valid_i     (rx_valid),
        .rx_clear_o     (rx_clear)
    );

    sram_controller u_base_sram (
        .clk_25m_i  (clk_25m_i),
        .rst_n_i    (rst_n_i),
        .a_req_i    (base_a),
        .b_req_i    (base_b),
        .a_rdata_o  (base_a_rdata),
        .b_rdata_o  (base_b_rdata),
        .stall_o    (base_stall),
        .ram_o      (base_ram_o),
        .ram_data_i (base_ram_data_i)
    );

    sram_controller u_ext_sram (
        .clk_25m_i  (clk_25m_i),
        .rst_n_i    (rst_n_i),
        .a_req_i    (ext_a),
        .b_req_i    (ext_b),
        .a_rdata_o  (ext_a_rdata),
        .b_rdata_o  (ext_b_rdata),
        .stall_o    (ext_stall),
        .ram_o      (ext_ram_o),
        .ram_data_i (ext_ram_data_i)
    );

    uart_tx u_uart_tx (
        .clk_25m_i (clk_25m_i),
        .rst_n_i   (rst_n_i),
        .start_i   (tx_start),
        .byte_i    (tx_byte),
        .busy_o    (tx_busy),
        .txd_o     (txd_o)
    );

    uart_rx u_uart_rx (
        .clk_25m_i (clk_25m_i),
        .rst_n_i   (rst_n_i),
        .rxd_i     (rxd_i),
        .clear_i   (rx_clear),
        .byte_o    (rx_byte),
        .valid_o   (rx_valid)
    );

    assign stall_o = base_stall | ext_stall;
    assign irq_o   = rx_valid;  // pending while a received byte waits

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import intomips_soc_pkg::*; (
    input  logic       clk_25m_i,
    input  logic       rst_n_i,
    input  logic       rxd_i,
    input  logic       clear_i,
    output logic [7:0] byte_o,
    output logic       valid_o
);

    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  active_q;
    logic                  sample;
    logic [UART_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;
    logic [7:0]            shift_q;
    logic [7:0]            byte_q;
    logic                  valid_q;

    // two-flop synchronizer, idle high
    always_ff @(posedge clk_25m_i) begin
        if (!rst_n_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    assign sample = active_q && (baud_cnt == UART_CNT_W'(UART_HALF_BIT - 1));

    always_ff @(posedge clk_25m_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            if (!active_q) begin
                if (!rxd_sync) begin  // falling edge of start bit
                    active_q <= 1'b1;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end else begin
                baud_cnt <= (baud_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) ?
                            '0 : baud_cnt + 1'b1;
                if (sample) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd0 && rxd_sync) begin
                        active_q <= 1'b0;  // glitch, not a start bit
                    end else if (bit_cnt == 4'd9) begin
                        active_q <= 1'b0;
                    end
                end
            end
            // a new byte wins over a clear in the same cycle
            if (sample && bit_cnt == 4'd9 && rxd_sync) begin
                valid_q <= 1'b1;
            end else if (clear_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_25m_i) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_q <= {rxd_sync, shift_q[7:1]};  // lsb arrives first
        end
        if (sample && bit_cnt == 4'd9 && rxd_sync) begin
            byte_q <= shift_q;
        end
    end

    assign byte_o  = byte_q;
    assign valid_o = valid_q;

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import intomips_soc_pkg::*; (
    input  logic       clk_25m_i,
    input  logic       rst_n_i,
    input  logic       start_i,
    input  logic [7:0] byte_i,
    output logic       busy_o,
    output logic       txd_o
);

    logic                  busy_q;
    logic [UART_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [9:0]            shift_q;

    always_ff @(posedge clk_25m_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q   <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy_q <= 1'b0;  // end of stop bit
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // frame is stop, data, start, shifted out lsb first
    always_ff @(posedge clk_25m_i) begin
        if (!busy_q && start_i) begin
            shift_q <= {1'b1, byte_i, 1'b0};
        end else if (busy_q && baud_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

    assign busy_o = busy_q;
    assign txd_o  = busy_q ? shift_q[0] : 1'b1;  // line idles high

endmodule

// File: rtl/sram_controller.sv
`timescale 1ns/1ns

module sram_controller import intomips_soc_pkg::*; (
    input  logic      clk_25m_i,
    input  logic      rst_n_i,
    input  cpu_req_t  a_req_i,
    input  cpu_req_t  b_req_i,
    output word_t     a_rdata_o,
    output word_t     b_rdata_o,
    output logic      stall_o,
    output sram_out_t ram_o,
    input  word_t     ram_data_i
);

    sram_state_e state_q;
    sram_state_e state_d;
    sram_state_e phase;     // effective state of this cycle
    cpu_req_t    cur_req;
    logic        a_act;
    logic        b_act;
    logic        in_setup;
    logic        in_strobe;
    word_t       a_rdata_q;
    word_t       b_rdata_q;

    assign a_act = a_req_i.re | a_req_i.we;
    assign b_act = b_req_i.re | b_req_i.we;

    // a new request uses its first cycle as setup, straight from IDLE
    always_comb begin
        phase = state_q;
        if (state_q == IDLE) begin
            if (a_act) begin
                phase = A_SETUP;
            end else if (b_act) begin
                phase = B_SETUP;
            end
        end
    end

    always_comb begin
        case (phase)
            A_SETUP:  state_d = A_STROBE;
            A_STROBE: state_d = b_act ? B_SETUP : DONE;
            B_SETUP:  state_d = B_STROBE;
            B_STROBE: state_d = DONE;
            default:  state_d = IDLE;  // DONE lets the cpu move on
        endcase
    end

    assign in_setup  = (phase == A_SETUP) || (phase == B_SETUP);
    assign in_strobe = (phase == A_STROBE) || (phase == B_STROBE);
    assign cur_req   = (phase == A_SETUP || phase == A_STROBE) ? a_req_i : b_req_i;
    assign stall_o   = in_setup | in_strobe;

    always_comb begin
        ram_o.addr    = cur_req.addr[21:2];
        ram_o.be_n    = ~cur_req.mask;
        ram_o.ce_n    = ~(in_setup | in_strobe);
        ram_o.oe_n    = ~((in_setup | in_strobe) & cur_req.re);
        ram_o.we_n    = ~(in_strobe & cur_req.we);  // we only in the strobe cycle
        ram_o.dout    = cur_req.wdata;
        ram_o.dout_en = (in_setup | in_strobe) & cur_req.we;
    end

    always_ff @(posedge clk_25m_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // read data captured at the end of the strobe, held afterwards
    always_ff @(posedge clk_25m_i) begin
        if (phase == A_STROBE && a_req_i.re) begin
            a_rdata_q <= ram_data_i;
        end
        if (phase == B_STROBE && b_req_i.re) begin
            b_rdata_q <= ram_data_i;
        end
    end

    assign a_rdata_o = a_rdata_q;
    assign b_rdata_o = b_rdata_q;

    a_no_we_oe: assert property (@(posedge clk_25m_i) disable iff (!rst_n_i)
        !(!ram_o.we_n && !ram_o.oe_n));

    // bus driven without we only while setting up, and the strobe follows
    a_dout_en: assert property (@(posedge clk_25m_i) disable iff (!rst_n_i)
        (ram_o.dout_en && ram_o.we_n) |-> in_setup ##1 !ram_o.we_n);

endmodule

// File: rtl/bus_router.sv
`timescale 1ns/1ns

module bus_router import intomips_soc_pkg::*; (
    input  logic       clk_25m_i,
    input  logic       rst_n_i,
    input  logic       inst_re_i,
    input  word_t      inst_addr_i,
    input  cpu_req_t   data_req_i,
    output word_t      inst_rdata_o,
    output word_t      data_rdata_o,
    output cpu_req_t   base_a_o,
    output cpu_req_t   base_b_o,
    output cpu_req_t   ext_a_o,
    output cpu_req_t   ext_b_o,
    input  word_t      base_a_rdata_i,
    input  word_t      base_b_rdata_i,
    input  word_t      ext_a_rdata_i,
    input  word_t      ext_b_rdata_i,
    output logic       tx_start_o,
    output logic [7:0] tx_byte_o,
    input  logic       tx_busy_i,
    input  logic [7:0] rx_byte_i,
    input  logic       rx_valid_i,
    output logic       rx_clear_o
);

    region_e  inst_region;
    region_e  data_region;
    cpu_req_t inst_req;

    function automatic region_e decode(input word_t addr);
        region_e r;
        r = REGION_NONE;
        if (addr >= BASE_LO && addr <= BASE_HI) begin
            r = REGION_BASE;
        end else if (addr >= EXT_LO && addr <= EXT_HI) begin
            r = REGION_EXT;
        end else if (addr == UART_DATA_ADDR) begin
            r = REGION_UART_DATA;
        end else if (addr == UART_STATUS_ADDR) begin
            r = REGION_UART_STATUS;
        end
        return r;
    endfunction

    assign inst_region = decode(inst_addr_i);
    assign data_region = decode(data_req_i.addr);

    // fetches are always full-word reads
    always_comb begin
        inst_req       = '0;
        inst_req.re    = inst_re_i;
        inst_req.addr  = inst_addr_i;
        inst_req.mask  = 4'hf;
    end

    // inst on the a-port, data on the b-port, even when alone on an sram
    assign base_a_o = (inst_region == REGION_BASE) ? inst_req : '0;
    assign ext_a_o  = (inst_region == REGION_EXT)  ? inst_req : '0;
    assign base_b_o = (data_region == REGION_BASE) ? data_req_i : '0;
    assign ext_b_o  = (data_region == REGION_EXT)  ? data_req_i : '0;

    always_comb begin
        case (inst_region)
            REGION_BASE: inst_rdata_o = base_a_rdata_i;
            REGION_EXT:  inst_rdata_o = ext_a_rdata_i;
            default:     inst_rdata_o = '0;  // uart or unmapped
        endcase
    end

    always_comb begin
        case (data_region)
            REGION_BASE:        data_rdata_o = base_b_rdata_i;
            REGION_EXT:         data_rdata_o = ext_b_rdata_i;
            REGION_UART_DATA:   data_rdata_o = {24'h0, rx_byte_i};
            REGION_UART_STATUS: data_rdata_o = {30'h0, rx_valid_i, ~tx_busy_i};
            default:            data_rdata_o = '0;
        endcase
    end

    // busy rises next cycle, so a held write only starts one frame
    assign tx_start_o = (data_region == REGION_UART_DATA) & data_req_i.we & ~tx_busy_i;
    assign tx_byte_o  = data_req_i.wdata[7:0];
    assign rx_clear_o = (data_region == REGION_UART_DATA) & data_req_i.re & rx_valid_i;

    // a start is only issued to an idle transmitter, and it takes it
    a_tx_start_idle: assert property (@(posedge clk_25m_i) disable iff (!rst_n_i)
        tx_start_o |-> !tx_busy_i ##1 tx_busy_i);

endmodule

// File: rtl/intomips_soc_pkg.sv
package intomips_soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  mask_t;       // byte mask, active high
    typedef logic [19:0] sram_addr_t;  // word address, bits 21..2

    typedef struct packed {
        logic  re;
        logic  we;
        word_t addr;
        word_t wdata;
        mask_t mask;
    } cpu_req_t;

    // pins of one asynchronous SRAM, strobes active low
    typedef struct packed {
        sram_addr_t addr;
        logic [3:0] be_n;
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
        word_t      dout;
        logic       dout_en;  // high while the controller drives the data bus
    } sram_out_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_BASE,
        REGION_EXT,
        REGION_UART_DATA,
        REGION_UART_STATUS
    } region_e;

    typedef enum logic [2:0] {
        IDLE,
        A_SETUP,
        A_STROBE,
        B_SETUP,
        B_STROBE,
        DONE
    } sram_state_e;

    // address map
    localparam word_t BASE_LO          = 32'h8000_0000;
    localparam word_t BASE_HI          = 32'h803F_FFFF;
    localparam word_t EXT_LO           = 32'h8040_0000;
    localparam word_t EXT_HI           = 32'h807F_FFFF;
    localparam word_t UART_DATA_ADDR   = 32'hBFD0_03F8;
    localparam word_t UART_STATUS_ADDR = 32'hBFD0_03FC;

    // serial timing
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_HALF_BIT     = UART_CLKS_PER_BIT / 2;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

endpackage
